// File: files.f
verilog/fp_div_pkg.sv
verilog/operand_unpack.sv
verilog/mantissa_divider.sv
verilog/result_pack.sv
verilog/fp_div.sv
bench/fp_div_assert.sv
bench/fp_div_tb.sv

// File: Makefile
SIM       = verilator
TOP       = fp_div_tb
FILELIST  = files.f
BUILD_DIR = obj_dir
LOG       = sim.log
FLAGS     = --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(BUILD_DIR)
RUN_ARGS  = +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Testbench failed" $(LOG); then \
	    echo "Simulation result: fail"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/fp_div_tb.sv
module fp_div_tb;

    import fp_div_pkg::*;

    localparam int num_tests     = 53;
    localparam int latency       = 26;
    localparam int wait_limit    = 40;
    localparam int watchdog_time = num_tests * 30 * 4 + 400;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               in_valid;
    logic [float_w-1:0] a;
    logic [float_w-1:0] b;
    logic               out_valid;
    logic [float_w-1:0] result;
    logic               exception;
    logic               busy;

    int          cycle        = 0;
    int          issued_count = 0;
    int          done_count   = 0;
    int          error_count  = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    logic [31:0] rng_state    = 32'he355;

    logic [float_w-1:0] want_result_q[$];
    logic               want_exc_q[$];
    string              name_q[$];
    int                 start_q[$];

    fp_div UUT
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .result    (result),
        .exception (exception),
        .busy      (busy)
    );

    initial
    begin
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
        cycle <= cycle + 1;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic void reference_div(input logic [float_w-1:0] x,
                                          input logic [float_w-1:0] y,
                                          output logic [float_w-1:0] res,
                                          output logic exc);
        logic [7:0]  ex;
        logic [7:0]  ey;
        logic [7:0]  e_out;
        logic [22:0] frac;
        logic [63:0] num;
        logic [63:0] den;
        logic [63:0] q;
        logic        s;
        s   = x[31] ^ y[31];
        ex  = x[30:23];
        ey  = y[30:23];
        exc = (ex == 8'hff) || (ey == 8'hff) || (ey == 8'h00);
        num = {40'd0, 1'b1, x[22:0]} << 24;
        den = {40'd0, 1'b1, y[22:0]};
        q   = num / den;
        // Leading one lands in bit 24 or bit 23
        if (q[24])
        begin
            frac  = q[23:1];
            e_out = ex - ey + 8'd127;
        end
        else
        begin
            frac  = q[22:0];
            e_out = ex - ey + 8'd126;
        end
        if (ex == 8'h00)
            res = {s, 31'd0};
        else if (exc)
            res = 32'hffff_ffff;
        else
            res = {s, e_out, frac};
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Exponent 64 to 190, any fraction and sign
    function automatic logic [float_w-1:0] random_normal();
        logic [7:0]  e;
        logic [22:0] f;
        logic        s;
        rng_state = lcg_next(rng_state);
        e = 8'(64 + rng_state[31:16] % 127);
        s = rng_state[15];
        rng_state = lcg_next(rng_state);
        f = rng_state[31:9];
        return {s, e, f};
    endfunction

    task automatic check_result(input string test, input logic [float_w-1:0] got,
                                input logic [float_w-1:0] want, inout bit ok);
        if (got !== want)
        begin
            $display("[ERROR] %s result: got %h, expected %h", test, got, want);
            error_count++;
            ok = 1'b0;
        end
    endtask

    task automatic check_flag(input string test, input logic got, input logic want,
                              inout bit ok);
        if (got !== want)
        begin
            $display("[ERROR] %s exception: got %h, expected %h", test, got, want);
            error_count++;
            ok = 1'b0;
        end
    endtask

    task automatic start_request(input string nm, input logic [float_w-1:0] x,
                                 input logic [float_w-1:0] y);
        logic [float_w-1:0] res;
        logic               exc;
        reference_div(x, y, res, exc);
        want_result_q.push_back(res);
        want_exc_q.push_back(exc);
        name_q.push_back(nm);
        issued_count++;
        @(posedge clk);
        in_valid <= 1'b1;
        a        <= x;
        b        <= y;
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_result(input string nm);
        int waited;
        waited = 0;
        while (done_count < issued_count && waited < wait_limit)
        begin
            @(posedge clk);
            waited++;
        end
        if (done_count < issued_count)
        begin
            $display("%s: no out_valid within %0d cycles", nm, wait_limit);
            error_count++;
            tests_failed++;
            done_count = issued_count;
            want_result_q.delete();
            want_exc_q.delete();
            name_q.delete();
            start_q.delete();
        end
    endtask

    task automatic run_test(input string nm, input logic [float_w-1:0] x,
                            input logic [float_w-1:0] y);
        start_request(nm, x, y);
        wait_result(nm);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Response checking
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        bit    ok;
        int    lat;
        string nm;
        forever
        begin
            @(negedge clk);
            if (rst_n && out_valid && busy)
            begin
                $display("busy is still high while out_valid is high");
                error_count++;
            end
            // Accepted on the coming edge, whose index is cycle
            if (rst_n && in_valid && !busy)
                start_q.push_back(cycle);
            if (rst_n && out_valid)
            begin
                done_count++;
                if (name_q.size() == 0)
                begin
                    $display("out_valid arrived with no request pending");
                    error_count++;
                end
                else
                begin
                    ok  = 1'b1;
                    nm  = name_q.pop_front();
                    lat = (start_q.size() == 0) ? -1 : cycle - 1 - start_q.pop_front();
                    if (lat != latency)
                    begin
                        $display("%s: out_valid came %0d cycles after the request, not %0d",
                                 nm, lat, latency);
                        error_count++;
                        ok = 1'b0;
                    end
                    check_result(nm, result, want_result_q.pop_front(), ok);
                    check_flag(nm, exception, want_exc_q.pop_front(), ok);
                    $display("%s: %s", nm, ok ? "pass" : "fail");
                    if (ok)
                        tests_passed++;
                    else
                        tests_failed++;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        logic [float_w-1:0] held_want;
        logic               held_exc;
        bit                 held_ok;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        a        = '0;
        b        = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < 40; i++)
            run_test($sformatf("random %0d", i), random_normal(), random_normal());

        // Pi over e with every sign pair
        run_test("sign ++", 32'h4049_0fdb, 32'h402d_f854);
        run_test("sign -+", 32'hc049_0fdb, 32'h402d_f854);
        run_test("sign +-", 32'h4049_0fdb, 32'hc02d_f854);
        run_test("sign --", 32'hc049_0fdb, 32'hc02d_f854);

        run_test("divide by zero", 32'h3f80_0000, 32'h0000_0000);
        run_test("a infinite", 32'h7f80_0000, 32'h3f80_0000);
        run_test("b nan", 32'h3f80_0000, 32'h7fc0_0000);
        run_test("negative by zero", 32'hc000_0000, 32'h8000_0000);

        run_test("zero dividend", 32'h0000_0000, 32'h4000_0000);
        run_test("negative zero dividend", 32'h8000_0000, 32'h4000_0000);
        run_test("zero by zero", 32'h0000_0000, 32'h8000_0000);
        run_test("zero by infinity", 32'h8000_0000, 32'h7f80_0000);

        // Second strobe lands mid-division and must be dropped
        start_request("busy ignore", 32'h3fc0_0000, 32'h4000_0000);
        repeat (10) @(posedge clk);
        in_valid <= 1'b1;
        a        <= 32'h4120_0000;
        b        <= 32'h3f80_0000;
        @(posedge clk);
        in_valid <= 1'b0;
        wait_result("busy ignore");
        repeat (30) @(posedge clk);
        @(negedge clk);
        if (done_count != issued_count)
        begin
            $display("a request issued while busy produced an extra out_valid");
            error_count++;
        end
        // Busy low during a strobe leaves an accepted request with no result
        if (start_q.size() != 0)
        begin
            $display("a request seen as accepted never produced out_valid");
            error_count++;
        end
        held_ok = 1'b1;
        reference_div(32'h3fc0_0000, 32'h4000_0000, held_want, held_exc);
        check_result("busy ignore held", result, held_want, held_ok);
        check_flag("busy ignore held", exception, held_exc, held_ok);

        $display("%0d tests run, %0d passed, %0d failed, %0d errors",
                 tests_passed + tests_failed, tests_passed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    initial
    begin
        #(watchdog_time);
        $display("Run did not finish within %0d time units", watchdog_time);
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: bench/fp_div_assert.sv
module fp_div_assert
(
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic busy,
    input logic out_valid
);

    // Result strobe lasts one cycle
    strobe_single: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |=> !out_valid)
    else
        $error("out_valid high for two cycles in a row");

    strobe_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> !busy)
    else
        $error("busy high while out_valid is high");

    // Set after edge k+26, first sampled high at edge k+27
    strobe_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (in_valid && !busy) |-> ##27 out_valid)
    else
        $error("out_valid missing 26 cycles after an accepted request");

endmodule

bind fp_div fp_div_assert u_assert
(
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .busy      (busy),
    .out_valid (out_valid)
);

// File: verilog/fp_div.sv
module fp_div
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            in_valid,
    input  logic [fp_div_pkg::float_w-1:0]  a,
    input  logic [fp_div_pkg::float_w-1:0]  b,
    output logic                            out_valid,
    output logic [fp_div_pkg::float_w-1:0]  result,
    output logic                            exception,
    output logic                            busy
);

    import fp_div_pkg::*;

    logic                accept;
    logic [sig_w-1:0]    sig_a;
    logic [sig_w-1:0]    sig_b;
    logic                sign;
    logic [exp_w-1:0]    exp_base;
    operand_class_t      class_a;
    operand_class_t      class_b;
    logic [quot_w-1:0]   quotient;
    logic                done;

    operand_unpack u_unpack
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .accept   (accept),
        .a        (a),
        .b        (b),
        .sig_a    (sig_a),
        .sig_b    (sig_b),
        .sign     (sign),
        .exp_base (exp_base),
        .class_a  (class_a),
        .class_b  (class_b)
    );

    // Owns the accept decision and the busy flag
    mantissa_divider u_divider
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .sig_a    (sig_a),
        .sig_b    (sig_b),
        .accept   (accept),
        .busy     (busy),
        .quotient (quotient),
        .done     (done)
    );

    result_pack u_pack
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .done      (done),
        .quotient  (quotient),
        .sign      (sign),
        .exp_base  (exp_base),
        .class_a   (class_a),
        .class_b   (class_b),
        .out_valid (out_valid),
        .result    (result),
        .exception (exception)
    );

endmodule

// File: verilog/result_pack.sv
module result_pack
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            done,
    input  logic [fp_div_pkg::quot_w-1:0]   quotient,
    input  logic                            sign,
    input  logic [fp_div_pkg::exp_w-1:0]    exp_base,
    input  fp_div_pkg::operand_class_t      class_a,
    input  fp_div_pkg::operand_class_t      class_b,
    output logic                            out_valid,
    output logic [fp_div_pkg::float_w-1:0]  result,
    output logic                            exception
);

    import fp_div_pkg::*;

    logic [frac_w-1:0]  frac_n;
    logic [exp_w-1:0]   exp_n;
    logic               exc_d;
    logic [float_w-1:0] result_d;

    ////////////////////////////////////////////////////////////////////////////
    // Normalize by at most one position
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        if (quotient[quot_w-1])
        begin
            frac_n = quotient[quot_w-2:1];
            exp_n  = exp_base;
        end
        else
        begin
            frac_n = quotient[frac_w-1:0];
            exp_n  = exp_base - 1'b1;
        end
    end

    assign exc_d = (class_a == class_special) || (class_b == class_special) ||
                   (class_b == class_zero);

    // Zero dividend wins over the exception word
    always_comb
    begin
        if (class_a == class_zero)
            result_d = {sign, {(float_w-1){1'b0}}};
        else if (exc_d)
            result_d = exception_word;
        else
            result_d = {sign, exp_n, frac_n};
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_valid <= 1'b0;
            result    <= '0;
            exception <= 1'b0;
        end
        else
        begin
            out_valid <= done;
            if (done)
            begin
                result    <= result_d;
                exception <= exc_d;
            end
        end
    end

endmodule

// File: verilog/mantissa_divider.sv
module mantissa_divider
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            in_valid,
    input  logic [fp_div_pkg::sig_w-1:0]    sig_a,
    input  logic [fp_div_pkg::sig_w-1:0]    sig_b,
    output logic                            accept,
    output logic                            busy,
    output logic [fp_div_pkg::quot_w-1:0]   quotient,
    output logic                            done
);

    import fp_div_pkg::*;

    div_state_t state;

    logic [$clog2(quot_w)-1:0] step_cnt;

    logic [sig_w:0]   rem;
    logic [sig_w-1:0] divisor;
    logic [sig_w+1:0] trial;
    logic             q_bit;
    logic [sig_w:0]   rem_next;

    ////////////////////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////////////////////

    assign accept = (state == div_idle) && in_valid;
    assign busy   = (state != div_idle);
    assign done   = (state == div_done);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= div_idle;
            step_cnt <= '0;
        end
        else
        begin
            case (state)
                div_idle:
                begin
                    if (in_valid)
                    begin
                        state    <= div_run;
                        step_cnt <= '0;
                    end
                end
                div_run:
                begin
                    step_cnt <= step_cnt + 1'b1;
                    if (int'(step_cnt) == quot_w - 1)
                        state <= div_done;
                end
                div_done:
                    state <= div_idle;
                default:
                    state <= div_idle;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Restoring step
    ////////////////////////////////////////////////////////////////////////////

    // Borrow out of the top bit means remainder < divisor
    assign trial = {1'b0, rem} - {2'b00, divisor};
    assign q_bit = ~trial[sig_w+1];

    // Remainder stays below divisor, so the shift never loses a bit
    assign rem_next = q_bit ? {trial[sig_w-1:0], 1'b0} : {rem[sig_w-1:0], 1'b0};

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            rem     <= {1'b0, sig_a};
            divisor <= sig_b;
        end
        else if (state == div_run)
        begin
            rem      <= rem_next;
            quotient <= {quotient[quot_w-2:0], q_bit};
        end
    end

endmodule

// File: verilog/operand_unpack.sv
module operand_unpack
(
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               accept,
    input  logic [fp_div_pkg::float_w-1:0]     a,
    input  logic [fp_div_pkg::float_w-1:0]     b,
    output logic [fp_div_pkg::sig_w-1:0]       sig_a,
    output logic [fp_div_pkg::sig_w-1:0]       sig_b,
    output logic                               sign,
    output logic [fp_div_pkg::exp_w-1:0]       exp_base,
    output fp_div_pkg::operand_class_t         class_a,
    output fp_div_pkg::operand_class_t         class_b
);

    import fp_div_pkg::*;

    logic [exp_w-1:0] exp_a;
    logic [exp_w-1:0] exp_b;
    logic [exp_w-1:0] exp_diff;

    function automatic operand_class_t classify(input logic [exp_w-1:0] exp_field);
        if (exp_field == '0)
            return class_zero;
        else if (exp_field == exp_w'(exp_max))
            return class_special;
        else
            return class_normal;
    endfunction

    assign exp_a = a[float_w-2:frac_w];
    assign exp_b = b[float_w-2:frac_w];

    // Hidden bit always set, zero operands are caught by class
    assign sig_a = {1'b1, a[frac_w-1:0]};
    assign sig_b = {1'b1, b[frac_w-1:0]};

    // Wraps modulo 256
    assign exp_diff = exp_a - exp_b + exp_w'(exp_bias);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sign     <= 1'b0;
            exp_base <= '0;
            class_a  <= class_zero;
            class_b  <= class_zero;
        end
        else if (accept)
        begin
            sign     <= a[float_w-1] ^ b[float_w-1];
            exp_base <= exp_diff;
            class_a  <= classify(exp_a);
            class_b  <= classify(exp_b);
        end
    end

endmodule

// File: verilog/fp_div_pkg.sv
package fp_div_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Single-precision format
    ////////////////////////////////////////////////////////////////////////////

    localparam int float_w = 32;
    localparam int exp_w   = 8;
    localparam int frac_w  = 23;

    // Fraction plus hidden bit
    localparam int sig_w   = 24;

    // One quotient bit per iteration
    localparam int quot_w  = 25;

    localparam int exp_bias = 127;
    localparam int exp_max  = 255;

    localparam logic [float_w-1:0] exception_word = '1;

    ////////////////////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////////////////////

    // Operand class from the exponent field alone
    typedef enum logic [1:0]
    {
        class_zero,
        class_special,
        class_normal
    } operand_class_t;

    typedef enum logic [1:0]
    {
        div_idle,
        div_run,
        div_done
    } div_state_t;

endpackage
